//--- csr_pkg.sv
/*
  shared definitions for the supervisor CSR file
  holds the datapath widths, the implemented CSR addresses, the exception
  causes, the status register bit positions and the software write masks
  the RTL and the testbench pull these in by a wildcard import
*/
package csr_pkg;

  // datapath widths
  localparam int CSR_WIDTH        = 64;
  localparam int CSR_ADDR_WIDTH   = 12;
  localparam int COMMIT_CNT_WIDTH = 3;
  localparam int VADDR_WIDTH      = 64;
  localparam int CAUSE_WIDTH      = 4;

  // implemented CSR addresses, everything else reads as zero
  typedef enum logic [CSR_ADDR_WIDTH-1:0] {
    CSR_FFLAGS   = 12'h001,
    CSR_FRM      = 12'h002,
    CSR_EPC      = 12'h502,
    CSR_BADVADDR = 12'h503,
    CSR_COUNT    = 12'h506,
    CSR_EVEC     = 12'h508,
    CSR_CAUSE    = 12'h509,
    CSR_STATUS   = 12'h50A
  } csr_addr_e;

  // exception causes reported by retire
  typedef enum logic [CAUSE_WIDTH-1:0] {
    MISALIGNED_FETCH = 4'd0,
    FAULT_FETCH      = 4'd1,
    ILLEGAL_INSTR    = 4'd2,
    MISALIGNED_LOAD  = 4'd8,
    MISALIGNED_STORE = 4'd9,
    FAULT_LOAD       = 4'd10,
    FAULT_STORE      = 4'd11
  } cause_e;

  // status register bit positions
  localparam int SR_S      = 0;
  localparam int SR_PS     = 1;
  localparam int SR_EI     = 2;
  localparam int SR_PEI    = 3;
  localparam int SR_EF     = 4;
  localparam int SR_U64    = 5;
  localparam int SR_S64    = 6;
  localparam int SR_VM     = 7;
  localparam int SR_EA     = 8;
  // interrupt mask field
  localparam int SR_IM_LSB = 16;
  localparam int SR_IM_MSB = 23;

  // supervisor mode with both 64-bit modes enabled, 0x61
  localparam logic [CSR_WIDTH-1:0] STATUS_RESET =
    (CSR_WIDTH'(1) << SR_S) | (CSR_WIDTH'(1) << SR_U64) | (CSR_WIDTH'(1) << SR_S64);

  // writable status bits, EA and the upper bits stay zero
  localparam logic [CSR_WIDTH-1:0] STATUS_WR_MASK =
    (CSR_WIDTH'(1) << SR_S)   | (CSR_WIDTH'(1) << SR_PS)  | (CSR_WIDTH'(1) << SR_EI) |
    (CSR_WIDTH'(1) << SR_PEI) | (CSR_WIDTH'(1) << SR_EF)  | (CSR_WIDTH'(1) << SR_U64) |
    (CSR_WIDTH'(1) << SR_S64) | (CSR_WIDTH'(1) << SR_VM)  |
    (CSR_WIDTH'({(SR_IM_MSB-SR_IM_LSB+1){1'b1}}) << SR_IM_LSB);

  // floating point CSRs only hold the low word
  localparam logic [CSR_WIDTH-1:0] FFLAGS_MASK = 64'h0000_0000_ffff_ffff;
  localparam logic [CSR_WIDTH-1:0] FRM_MASK    = 64'h0000_0000_ffff_ffff;

endpackage

//--- csr_write_stage.sv
/*
  staging register for the single outstanding CSR write
  the write is captured at execute and released as a one-cycle commit
  strobe when the CSR instruction retires, so a squashed CSR instruction
  never changes architectural state
*/
`timescale 1ns/1ps

module csr_write_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               flush_i,
  input  logic                               commit_i,
  input  logic                               wr_en_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] wr_addr_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      wr_data_i,
  output logic                               commit_wr_o,
  output logic [csr_pkg::CSR_ADDR_WIDTH-1:0] commit_addr_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]      commit_data_o
);

  import csr_pkg::*;

  // staged write still belongs to a live instruction
  logic wr_valid;

  // only one CSR instruction is in flight, so one slot is enough
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      commit_addr_o <= wr_addr_i;
      commit_data_o <= wr_data_i;
    end
  end

  // a new write beats a flush in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_valid <= 1'b0;
    end
    else if (wr_en_i)
    begin
      wr_valid <= 1'b1;
    end
    else if (flush_i)
    begin
      wr_valid <= 1'b0;
    end
  end

  // commit only lands if the staged write survived any flush
  assign commit_wr_o = commit_i & wr_valid;

endmodule

//--- csr_storage.sv
/*
  architectural storage for the supervisor CSRs
  applies committed software writes with their masks, captures exception
  state, advances the retire counter, accumulates floating point flags and
  performs the supervisor return on status
  a committed write to a register overrides its own update in that cycle
*/
`timescale 1ns/1ps

module csr_storage (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 commit_wr_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0]   commit_addr_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]        commit_data_i,
  input  logic [csr_pkg::COMMIT_CNT_WIDTH-1:0] commit_cnt_i,
  input  logic                                 exc_flag_i,
  input  logic [csr_pkg::VADDR_WIDTH-1:0]      exc_pc_i,
  input  logic [csr_pkg::CAUSE_WIDTH-1:0]      exc_cause_i,
  input  logic [csr_pkg::VADDR_WIDTH-1:0]      st_commit_addr_i,
  input  logic [csr_pkg::VADDR_WIDTH-1:0]      ld_commit_addr_i,
  input  logic                                 sret_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]        fflags_i,
  output logic [csr_pkg::CSR_WIDTH-1:0]        fflags_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        frm_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        epc_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        badvaddr_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        count_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        evec_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        cause_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        status_o
);

  import csr_pkg::*;

  // per register write enables from the commit decode
  logic wr_fflags;
  logic wr_frm;
  logic wr_epc;
  logic wr_badvaddr;
  logic wr_count;
  logic wr_evec;
  logic wr_cause;
  logic wr_status;

  // autonomous next values when software does not write
  logic [CSR_WIDTH-1:0] fflags_next;
  logic [CSR_WIDTH-1:0] epc_next;
  logic [CSR_WIDTH-1:0] badvaddr_next;
  logic [CSR_WIDTH-1:0] count_next;
  logic [CSR_WIDTH-1:0] cause_next;
  logic [CSR_WIDTH-1:0] status_next;

  // commit address decode
  always_comb
  begin
    wr_fflags   = 1'b0;
    wr_frm      = 1'b0;
    wr_epc      = 1'b0;
    wr_badvaddr = 1'b0;
    wr_count    = 1'b0;
    wr_evec     = 1'b0;
    wr_cause    = 1'b0;
    wr_status   = 1'b0;
    if (commit_wr_i)
    begin
      case (commit_addr_i)
        CSR_FFLAGS:   wr_fflags   = 1'b1;
        CSR_FRM:      wr_frm      = 1'b1;
        CSR_EPC:      wr_epc      = 1'b1;
        CSR_BADVADDR: wr_badvaddr = 1'b1;
        CSR_COUNT:    wr_count    = 1'b1;
        CSR_EVEC:     wr_evec     = 1'b1;
        CSR_CAUSE:    wr_cause    = 1'b1;
        CSR_STATUS:   wr_status   = 1'b1;
        // writes to unimplemented addresses are dropped
        default:      ;
      endcase
    end
  end

  // sticky flags from retiring FP instructions
  assign fflags_next = fflags_o | (fflags_i & FFLAGS_MASK);

  // exception PC and cause
  assign epc_next   = exc_flag_i ? CSR_WIDTH'(exc_pc_i) : epc_o;
  assign cause_next = exc_flag_i ? CSR_WIDTH'(exc_cause_i) : cause_o;

  // retired count, an excepting instruction also counts as one
  assign count_next = count_o + CSR_WIDTH'(commit_cnt_i) + CSR_WIDTH'(exc_flag_i);

  // faulting address depends on which unit raised the exception
  always_comb
  begin
    badvaddr_next = badvaddr_o;
    if (exc_flag_i)
    begin
      case (exc_cause_i)
        MISALIGNED_FETCH, FAULT_FETCH:
          badvaddr_next = CSR_WIDTH'(exc_pc_i);
        MISALIGNED_LOAD, FAULT_LOAD:
          badvaddr_next = CSR_WIDTH'(ld_commit_addr_i);
        MISALIGNED_STORE, FAULT_STORE:
          badvaddr_next = CSR_WIDTH'(st_commit_addr_i);
        // illegal instruction and others carry no address
        default:
          badvaddr_next = badvaddr_o;
      endcase
    end
  end

  // sret restores mode and interrupt enable from the saved copies
  always_comb
  begin
    status_next = status_o;
    if (sret_i)
    begin
      status_next[SR_S]  = status_o[SR_PS];
      status_next[SR_EI] = status_o[SR_PEI];
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fflags_o   <= '0;
      frm_o      <= '0;
      epc_o      <= '0;
      badvaddr_o <= '0;
      count_o    <= '0;
      evec_o     <= '0;
      cause_o    <= '0;
      status_o   <= STATUS_RESET;
    end
    else
    begin
      fflags_o   <= wr_fflags   ? (commit_data_i & FFLAGS_MASK) : fflags_next;
      frm_o      <= wr_frm      ? (commit_data_i & FRM_MASK) : frm_o;
      epc_o      <= wr_epc      ? commit_data_i : epc_next;
      badvaddr_o <= wr_badvaddr ? commit_data_i : badvaddr_next;
      count_o    <= wr_count    ? commit_data_i : count_next;
      evec_o     <= wr_evec     ? commit_data_i : evec_o;
      cause_o    <= wr_cause    ? commit_data_i : cause_next;
      status_o   <= wr_status   ? (commit_data_i & STATUS_WR_MASK) : status_next;
    end
  end

endmodule

//--- csr_read_check.sv
/*
  CSR read port and read atomicity check
  read data follows the address combinationally, unknown addresses read zero
  a read is checkpointed so retire can replay the CSR instruction when the
  register it read has changed before the instruction commits
*/
`timescale 1ns/1ps

module csr_read_check (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               flush_i,
  input  logic                               commit_i,
  input  logic                               rd_en_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] rd_addr_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      fflags_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      frm_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      epc_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      badvaddr_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      count_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      evec_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      cause_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      status_i,
  output logic [csr_pkg::CSR_WIDTH-1:0]      rd_data_o,
  output logic                               atomic_vio_o
);

  import csr_pkg::*;

  // checkpoint of the last CSR read
  logic                      chkpt_valid;
  logic [CSR_ADDR_WIDTH-1:0] chkpt_addr;
  logic [CSR_WIDTH-1:0]      chkpt_data;
  // current value of the checkpointed register
  logic [CSR_WIDTH-1:0]      chkpt_cur;
  // read address hits an implemented register
  logic                      rd_impl;

  // register select shared by the read port and the checkpoint compare
  function automatic logic [CSR_WIDTH-1:0] csr_value(input logic [CSR_ADDR_WIDTH-1:0] addr);
    case (addr)
      CSR_FFLAGS:   csr_value = fflags_i;
      CSR_FRM:      csr_value = frm_i;
      CSR_EPC:      csr_value = epc_i;
      CSR_BADVADDR: csr_value = badvaddr_i;
      CSR_COUNT:    csr_value = count_i;
      CSR_EVEC:     csr_value = evec_i;
      CSR_CAUSE:    csr_value = cause_i;
      CSR_STATUS:   csr_value = status_i;
      default:      csr_value = '0;
    endcase
  endfunction

  always_comb
  begin
    rd_data_o = csr_value(rd_addr_i);
    chkpt_cur = csr_value(chkpt_addr);
    rd_impl   = rd_addr_i inside {CSR_FFLAGS, CSR_FRM, CSR_EPC, CSR_BADVADDR,
                                  CSR_COUNT, CSR_EVEC, CSR_CAUSE, CSR_STATUS};
  end

  // address and data of the read under watch
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chkpt_addr <= rd_addr_i;
      chkpt_data <= rd_data_o;
    end
  end

  // a new read wins over flush or commit in the same cycle
  // reads of unimplemented addresses are never watched
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chkpt_valid <= 1'b0;
    end
    else if (rd_en_i)
    begin
      chkpt_valid <= rd_impl;
    end
    else if (flush_i | commit_i)
    begin
      chkpt_valid <= 1'b0;
    end
  end

  // value moved under the in-flight CSR instruction
  assign atomic_vio_o = chkpt_valid & (chkpt_cur != chkpt_data);

endmodule

//--- csr_file.sv
/*
  supervisor CSR file top level
  stages writes until commit, holds the registers, serves reads and flags
  non-atomic reads for replay at retire
  epc, evec, status and frm also leave directly for fetch and the FPU
*/
`timescale 1ns/1ps

module csr_file (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 flush_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0]   wr_addr_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]        wr_data_i,
  input  logic                                 wr_en_i,
  input  logic                                 commit_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0]   rd_addr_i,
  input  logic                                 rd_en_i,
  input  logic [csr_pkg::COMMIT_CNT_WIDTH-1:0] commit_cnt_i,
  input  logic                                 exc_flag_i,
  input  logic [csr_pkg::VADDR_WIDTH-1:0]      exc_pc_i,
  input  logic [csr_pkg::CAUSE_WIDTH-1:0]      exc_cause_i,
  input  logic [csr_pkg::VADDR_WIDTH-1:0]      st_commit_addr_i,
  input  logic [csr_pkg::VADDR_WIDTH-1:0]      ld_commit_addr_i,
  input  logic                                 sret_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]        fflags_i,
  output logic [csr_pkg::CSR_WIDTH-1:0]        rd_data_o,
  output logic                                 atomic_vio_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        epc_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        evec_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        status_o,
  output logic [csr_pkg::CSR_WIDTH-1:0]        frm_o
);

  import csr_pkg::*;

  // staged write released at commit
  logic                      commit_wr;
  logic [CSR_ADDR_WIDTH-1:0] commit_addr;
  logic [CSR_WIDTH-1:0]      commit_data;

  // registers that only the read port sees
  logic [CSR_WIDTH-1:0]      fflags;
  logic [CSR_WIDTH-1:0]      badvaddr;
  logic [CSR_WIDTH-1:0]      count;
  logic [CSR_WIDTH-1:0]      cause;

  csr_write_stage csr_write_stage_i (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush_i),
    .commit_i      (commit_i),
    .wr_en_i       (wr_en_i),
    .wr_addr_i     (wr_addr_i),
    .wr_data_i     (wr_data_i),
    .commit_wr_o   (commit_wr),
    .commit_addr_o (commit_addr),
    .commit_data_o (commit_data)
  );

  // epc, evec, status and frm go straight to the top ports
  csr_storage csr_storage_i (
    .clk              (clk),
    .reset            (reset),
    .commit_wr_i      (commit_wr),
    .commit_addr_i    (commit_addr),
    .commit_data_i    (commit_data),
    .commit_cnt_i     (commit_cnt_i),
    .exc_flag_i       (exc_flag_i),
    .exc_pc_i         (exc_pc_i),
    .exc_cause_i      (exc_cause_i),
    .st_commit_addr_i (st_commit_addr_i),
    .ld_commit_addr_i (ld_commit_addr_i),
    .sret_i           (sret_i),
    .fflags_i         (fflags_i),
    .fflags_o         (fflags),
    .frm_o            (frm_o),
    .epc_o            (epc_o),
    .badvaddr_o       (badvaddr),
    .count_o          (count),
    .evec_o           (evec_o),
    .cause_o          (cause),
    .status_o         (status_o)
  );

  csr_read_check csr_read_check_i (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .fflags_i     (fflags),
    .frm_i        (frm_o),
    .epc_i        (epc_o),
    .badvaddr_i   (badvaddr),
    .count_i      (count),
    .evec_i       (evec_o),
    .cause_i      (cause),
    .status_i     (status_o),
    .rd_data_o    (rd_data_o),
    .atomic_vio_o (atomic_vio_o)
  );

endmodule

//--- csr_file_sva.sv
/*
  concurrent checks on the CSR file top level
  attached to every csr_file instance by the bind at the end of this file
  covers the violation flag after reset, its dependence on an open
  checkpoint, and zero read data for unimplemented addresses
*/
`timescale 1ns/1ps

module csr_file_sva (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               flush_i,
  input  logic                               commit_i,
  input  logic                               rd_en_i,
  input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] rd_addr_i,
  input  logic [csr_pkg::CSR_WIDTH-1:0]      rd_data_i,
  input  logic                               atomic_vio_i
);

  import csr_pkg::*;

  // a read was taken and nothing has closed it since
  logic read_open;
  // read address hits a kept register
  logic rd_impl;

  assign rd_impl = rd_addr_i inside {CSR_FFLAGS, CSR_FRM, CSR_EPC, CSR_BADVADDR,
                                     CSR_COUNT, CSR_EVEC, CSR_CAUSE, CSR_STATUS};

  // new read beats flush or commit in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      read_open <= 1'b0;
    end
    else if (rd_en_i)
    begin
      read_open <= 1'b1;
    end
    else if (flush_i | commit_i)
    begin
      read_open <= 1'b0;
    end
  end

  // flag starts low once reset is released
  vio_low_after_reset : assert property (@(posedge clk) $fell(reset) |-> !atomic_vio_i)
    else $error("atomic violation flag high right after reset");

  // flag only follows an open checkpoint
  vio_needs_read : assert property (@(posedge clk) disable iff (reset)
    atomic_vio_i |-> read_open)
    else $error("atomic violation flag high without an open read");

  // unknown addresses read back zero
  unimpl_reads_zero : assert property (@(posedge clk) disable iff (reset)
    !rd_impl |-> (rd_data_i == '0))
    else $error("nonzero read data for an unimplemented address");

endmodule

bind csr_file csr_file_sva csr_file_sva_i (
  .clk          (clk),
  .reset        (reset),
  .flush_i      (flush_i),
  .commit_i     (commit_i),
  .rd_en_i      (rd_en_i),
  .rd_addr_i    (rd_addr_i),
  .rd_data_i    (rd_data_o),
  .atomic_vio_i (atomic_vio_o)
);

//--- tb_csr_file.sv
/*
  table-driven testbench for the supervisor CSR file
  each table row is one operation or one check, applied in order by a loop
  a reference model tracks the kept registers, random data comes from a
  Galois LFSR, and a watchdog bounds the whole run
*/
`timescale 1ns/1ps

module tb_csr_file;

  import csr_pkg::*;

  // table operations
  typedef enum int {
    OP_STAGE, OP_COMMIT, OP_FLUSH, OP_FFLAGS, OP_EXC, OP_CNT,
    OP_SRET, OP_RDCP, OP_RD, OP_CHK, OP_VIO
  } op_e;

  logic                        clk;
  logic                        reset;
  logic                        flush_i;
  logic [CSR_ADDR_WIDTH-1:0]   wr_addr_i;
  logic [CSR_WIDTH-1:0]        wr_data_i;
  logic                        wr_en_i;
  logic                        commit_i;
  logic [CSR_ADDR_WIDTH-1:0]   rd_addr_i;
  logic                        rd_en_i;
  logic [COMMIT_CNT_WIDTH-1:0] commit_cnt_i;
  logic                        exc_flag_i;
  logic [VADDR_WIDTH-1:0]      exc_pc_i;
  logic [CAUSE_WIDTH-1:0]      exc_cause_i;
  logic [VADDR_WIDTH-1:0]      st_commit_addr_i;
  logic [VADDR_WIDTH-1:0]      ld_commit_addr_i;
  logic                        sret_i;
  logic [CSR_WIDTH-1:0]        fflags_i;
  logic [CSR_WIDTH-1:0]        rd_data_o;
  logic                        atomic_vio_o;
  logic [CSR_WIDTH-1:0]        epc_o;
  logic [CSR_WIDTH-1:0]        evec_o;
  logic [CSR_WIDTH-1:0]        status_o;
  logic [CSR_WIDTH-1:0]        frm_o;

  // stimulus table, one entry per row in each queue
  op_e                       op_q[$];
  logic [CSR_ADDR_WIDTH-1:0] addr_q[$];
  logic [CSR_WIDTH-1:0]      data_q[$];
  logic [CAUSE_WIDTH-1:0]    cause_q[$];
  logic [CSR_WIDTH-1:0]      exp_q[$];
  bit                        rnd_q[$];

  // reference model of the kept registers and the staged write
  logic [CSR_WIDTH-1:0]      m_fflags;
  logic [CSR_WIDTH-1:0]      m_frm;
  logic [CSR_WIDTH-1:0]      m_epc;
  logic [CSR_WIDTH-1:0]      m_badvaddr;
  logic [CSR_WIDTH-1:0]      m_count;
  logic [CSR_WIDTH-1:0]      m_evec;
  logic [CSR_WIDTH-1:0]      m_cause;
  logic [CSR_WIDTH-1:0]      m_status;
  logic [CSR_ADDR_WIDTH-1:0] m_stage_addr;
  logic [CSR_WIDTH-1:0]      m_stage_data;
  bit                        m_stage_valid;

  logic [31:0]               lfsr_state;
  logic [CAUSE_WIDTH-1:0]    exc_causes [7];
  bit                        row_ok;
  int                        n_pass;
  int                        n_fail;

  csr_file csr_file_i (
    .clk              (clk),
    .reset            (reset),
    .flush_i          (flush_i),
    .wr_addr_i        (wr_addr_i),
    .wr_data_i        (wr_data_i),
    .wr_en_i          (wr_en_i),
    .commit_i         (commit_i),
    .rd_addr_i        (rd_addr_i),
    .rd_en_i          (rd_en_i),
    .commit_cnt_i     (commit_cnt_i),
    .exc_flag_i       (exc_flag_i),
    .exc_pc_i         (exc_pc_i),
    .exc_cause_i      (exc_cause_i),
    .st_commit_addr_i (st_commit_addr_i),
    .ld_commit_addr_i (ld_commit_addr_i),
    .sret_i           (sret_i),
    .fflags_i         (fflags_i),
    .rd_data_o        (rd_data_o),
    .atomic_vio_o     (atomic_vio_o),
    .epc_o            (epc_o),
    .evec_o           (evec_o),
    .status_o         (status_o),
    .frm_o            (frm_o)
  );

  // 20 ns clock
  initial
  begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  // bound on the whole run
  initial
  begin
    #100000;
    $display("watchdog expired before the table finished");
    $display("Verification failed");
    $finish;
  end

  // one Galois step, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic rand_word(output logic [CSR_WIDTH-1:0] v);
    for (int b = 0; b < CSR_WIDTH; b++)
    begin
      v[b]       = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_value(input string name, input logic [CSR_WIDTH-1:0] expected,
                             input logic [CSR_WIDTH-1:0] actual);
    if (expected !== actual)
    begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      row_ok = 1'b0;
    end
  endtask

  task automatic add_row(input op_e op, input logic [CSR_ADDR_WIDTH-1:0] addr,
                         input logic [CSR_WIDTH-1:0] data, input logic [CAUSE_WIDTH-1:0] cause,
                         input logic [CSR_WIDTH-1:0] expected, input bit rnd);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    cause_q.push_back(cause);
    exp_q.push_back(expected);
    rnd_q.push_back(rnd);
  endtask

  function automatic logic [CSR_WIDTH-1:0] model_read(input logic [CSR_ADDR_WIDTH-1:0] addr);
    case (addr)
      CSR_FFLAGS:   model_read = m_fflags;
      CSR_FRM:      model_read = m_frm;
      CSR_EPC:      model_read = m_epc;
      CSR_BADVADDR: model_read = m_badvaddr;
      CSR_COUNT:    model_read = m_count;
      CSR_EVEC:     model_read = m_evec;
      CSR_CAUSE:    model_read = m_cause;
      CSR_STATUS:   model_read = m_status;
      default:      model_read = '0;
    endcase
  endfunction

  // committed software write with the per register masks
  task automatic model_write(input logic [CSR_ADDR_WIDTH-1:0] addr,
                             input logic [CSR_WIDTH-1:0] data);
    case (addr)
      CSR_FFLAGS:   m_fflags   = data & FFLAGS_MASK;
      CSR_FRM:      m_frm      = data & FRM_MASK;
      CSR_EPC:      m_epc      = data;
      CSR_BADVADDR: m_badvaddr = data;
      CSR_COUNT:    m_count    = data;
      CSR_EVEC:     m_evec     = data;
      CSR_CAUSE:    m_cause    = data;
      CSR_STATUS:   m_status   = data & STATUS_WR_MASK;
      default:      ;
    endcase
  endtask

  // model effect of one pulse row, taken at the same edge as the DUT
  task automatic model_step(input op_e op, input logic [CSR_ADDR_WIDTH-1:0] addr,
                            input logic [CSR_WIDTH-1:0] data,
                            input logic [CAUSE_WIDTH-1:0] cause);
    case (op)
      OP_STAGE:
      begin
        m_stage_addr  = addr;
        m_stage_data  = data;
        m_stage_valid = 1'b1;
      end
      OP_COMMIT, OP_RDCP:
      begin
        if (m_stage_valid)
          model_write(m_stage_addr, m_stage_data);
      end
      OP_FLUSH:  m_stage_valid = 1'b0;
      OP_FFLAGS: m_fflags = m_fflags | (data & FFLAGS_MASK);
      OP_CNT:    m_count = m_count + CSR_WIDTH'(data[2:0]);
      OP_EXC:
      begin
        m_epc   = data;
        m_cause = CSR_WIDTH'(cause);
        // excepting instruction counts as one more
        m_count = m_count + CSR_WIDTH'(data[2:0]) + 64'd1;
        case (cause)
          MISALIGNED_FETCH, FAULT_FETCH:  m_badvaddr = data;
          MISALIGNED_LOAD, FAULT_LOAD:    m_badvaddr = ~data;
          MISALIGNED_STORE, FAULT_STORE:  m_badvaddr = {data[31:0], data[63:32]};
          default:                        ;
        endcase
      end
      OP_SRET:
      begin
        m_status[SR_S]  = m_status[SR_PS];
        m_status[SR_EI] = m_status[SR_PEI];
      end
      default: ;
    endcase
  endtask

  // load address is the inverted pc, store address the swapped pc
  task automatic drive_pulse(input op_e op, input logic [CSR_ADDR_WIDTH-1:0] addr,
                             input logic [CSR_WIDTH-1:0] data,
                             input logic [CAUSE_WIDTH-1:0] cause);
    case (op)
      OP_STAGE:
      begin
        wr_en_i   <= 1'b1;
        wr_addr_i <= addr;
        wr_data_i <= data;
      end
      OP_COMMIT: commit_i <= 1'b1;
      OP_FLUSH:  flush_i <= 1'b1;
      OP_FFLAGS: fflags_i <= data;
      OP_CNT:    commit_cnt_i <= data[2:0];
      OP_SRET:   sret_i <= 1'b1;
      OP_EXC:
      begin
        exc_flag_i       <= 1'b1;
        exc_pc_i         <= data;
        exc_cause_i      <= cause;
        ld_commit_addr_i <= ~data;
        st_commit_addr_i <= {data[31:0], data[63:32]};
        commit_cnt_i     <= data[2:0];
      end
      // read issues while the staged write commits
      OP_RDCP:
      begin
        rd_en_i   <= 1'b1;
        rd_addr_i <= addr;
        commit_i  <= 1'b1;
      end
      default: ;
    endcase
  endtask

  task automatic clear_strobes();
    wr_en_i      <= 1'b0;
    commit_i     <= 1'b0;
    flush_i      <= 1'b0;
    rd_en_i      <= 1'b0;
    exc_flag_i   <= 1'b0;
    sret_i       <= 1'b0;
    fflags_i     <= '0;
    commit_cnt_i <= '0;
  endtask

  task automatic run_row(input int idx);
    op_e                  op;
    logic [CSR_WIDTH-1:0] data;
    string                name;
    op   = op_q[idx];
    data = data_q[idx];
    if (rnd_q[idx])
      rand_word(data);
    name   = $sformatf("%0d_%s_%03h", idx, op.name(), addr_q[idx]);
    row_ok = 1'b1;
    case (op)
      OP_RD, OP_CHK, OP_VIO:
      begin
        @(posedge clk);
        rd_addr_i <= addr_q[idx];
        // outputs settle well before the falling edge
        @(negedge clk);
        if (op == OP_CHK)
          check_value(name, exp_q[idx], rd_data_o);
        else if (op == OP_VIO)
          check_value(name, exp_q[idx], {63'b0, atomic_vio_o});
        else
        begin
          check_value(name, model_read(addr_q[idx]), rd_data_o);
          case (addr_q[idx])
            CSR_EPC:    check_value(name, m_epc, epc_o);
            CSR_EVEC:   check_value(name, m_evec, evec_o);
            CSR_STATUS: check_value(name, m_status, status_o);
            CSR_FRM:    check_value(name, m_frm, frm_o);
            default:    ;
          endcase
        end
      end
      default:
      begin
        @(posedge clk);
        drive_pulse(op, addr_q[idx], data, cause_q[idx]);
        @(posedge clk);
        clear_strobes();
        model_step(op, addr_q[idx], data, cause_q[idx]);
      end
    endcase
    if (row_ok)
    begin
      n_pass++;
      $display("pass %s", name);
    end
    else
    begin
      n_fail++;
      $display("fail %s", name);
    end
  endtask

  task automatic build_table();
    exc_causes = '{MISALIGNED_FETCH, FAULT_FETCH, ILLEGAL_INSTR, MISALIGNED_LOAD,
                   MISALIGNED_STORE, FAULT_LOAD, FAULT_STORE};
    // reset values
    add_row(OP_CHK, CSR_FFLAGS, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_FRM, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_EPC, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_BADVADDR, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_COUNT, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_EVEC, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_CAUSE, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_STATUS, '0, '0, 64'h61, 1'b0);
    // staged write stays hidden until commit, flush cancels it
    add_row(OP_STAGE, CSR_EVEC, '0, '0, '0, 1'b1);
    add_row(OP_RD, CSR_EVEC, '0, '0, '0, 1'b0);
    add_row(OP_COMMIT, '0, '0, '0, '0, 1'b0);
    add_row(OP_RD, CSR_EVEC, '0, '0, '0, 1'b0);
    add_row(OP_STAGE, CSR_EVEC, '0, '0, '0, 1'b1);
    add_row(OP_FLUSH, '0, '0, '0, '0, 1'b0);
    add_row(OP_COMMIT, '0, '0, '0, '0, 1'b0);
    add_row(OP_RD, CSR_EVEC, '0, '0, '0, 1'b0);
    // write masks and sticky flags
    add_row(OP_STAGE, CSR_FFLAGS, 64'hdead_beef_0000_0011, '0, '0, 1'b0);
    add_row(OP_COMMIT, '0, '0, '0, '0, 1'b0);
    add_row(OP_FFLAGS, '0, 64'h1234_0000_0000_0102, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_FFLAGS, '0, '0, 64'h113, 1'b0);
    add_row(OP_FFLAGS, '0, '0, '0, '0, 1'b1);
    add_row(OP_RD, CSR_FFLAGS, '0, '0, '0, 1'b0);
    add_row(OP_STAGE, CSR_FRM, '0, '0, '0, 1'b1);
    add_row(OP_COMMIT, '0, '0, '0, '0, 1'b0);
    add_row(OP_RD, CSR_FRM, '0, '0, '0, 1'b0);
    add_row(OP_STAGE, CSR_STATUS, 64'hffff_ffff_ffff_ffff, '0, '0, 1'b0);
    add_row(OP_COMMIT, '0, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_STATUS, '0, '0, 64'hff_00ff, 1'b0);
    add_row(OP_CHK, 12'h7c0, '0, '0, '0, 1'b0);
    // exception capture for every cause
    for (int k = 0; k < 7; k++)
    begin
      add_row(OP_EXC, '0, '0, exc_causes[k], '0, 1'b1);
      add_row(OP_RD, CSR_EPC, '0, '0, '0, 1'b0);
      add_row(OP_RD, CSR_CAUSE, '0, '0, '0, 1'b0);
      add_row(OP_RD, CSR_BADVADDR, '0, '0, '0, 1'b0);
    end
    // retire counter over mixed commits and an exception
    add_row(OP_CNT, '0, 64'd3, '0, '0, 1'b0);
    add_row(OP_CNT, '0, 64'd7, '0, '0, 1'b0);
    add_row(OP_EXC, '0, '0, FAULT_LOAD, '0, 1'b1);
    add_row(OP_CNT, '0, 64'd5, '0, '0, 1'b0);
    add_row(OP_RD, CSR_COUNT, '0, '0, '0, 1'b0);
    // sret with PS and PEI set, S and EI clear
    add_row(OP_STAGE, CSR_STATUS, 64'h6a, '0, '0, 1'b0);
    add_row(OP_COMMIT, '0, '0, '0, '0, 1'b0);
    add_row(OP_RD, CSR_STATUS, '0, '0, '0, 1'b0);
    add_row(OP_SRET, '0, '0, '0, '0, 1'b0);
    add_row(OP_CHK, CSR_STATUS, '0, '0, 64'h6f, 1'b0);
    // read atomicity on frm
    add_row(OP_STAGE, CSR_FRM, 64'h5, '0, '0, 1'b0);
    add_row(OP_COMMIT, '0, '0, '0, '0, 1'b0);
    add_row(OP_STAGE, CSR_FRM, 64'h9, '0, '0, 1'b0);
    add_row(OP_RDCP, CSR_FRM, '0, '0, '0, 1'b0);
    add_row(OP_VIO, CSR_FRM, '0, '0, 64'h1, 1'b0);
    add_row(OP_FLUSH, '0, '0, '0, '0, 1'b0);
    add_row(OP_VIO, CSR_FRM, '0, '0, 64'h0, 1'b0);
    add_row(OP_STAGE, CSR_FRM, 64'h9, '0, '0, 1'b0);
    add_row(OP_RDCP, CSR_FRM, '0, '0, '0, 1'b0);
    add_row(OP_VIO, CSR_FRM, '0, '0, 64'h0, 1'b0);
    add_row(OP_RD, CSR_FRM, '0, '0, '0, 1'b0);
  endtask

  initial
  begin
    reset            = 1'b1;
    flush_i          = 1'b0;
    wr_addr_i        = '0;
    wr_data_i        = '0;
    wr_en_i          = 1'b0;
    commit_i         = 1'b0;
    rd_addr_i        = '0;
    rd_en_i          = 1'b0;
    commit_cnt_i     = '0;
    exc_flag_i       = 1'b0;
    exc_pc_i         = '0;
    exc_cause_i      = '0;
    st_commit_addr_i = '0;
    ld_commit_addr_i = '0;
    sret_i           = 1'b0;
    fflags_i         = '0;
    lfsr_state       = 32'h3ae9_3b6f;
    n_pass           = 0;
    n_fail           = 0;
    m_fflags         = '0;
    m_frm            = '0;
    m_epc            = '0;
    m_badvaddr       = '0;
    m_count          = '0;
    m_evec           = '0;
    m_cause          = '0;
    m_status         = STATUS_RESET;
    m_stage_addr     = '0;
    m_stage_data     = '0;
    m_stage_valid    = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < op_q.size(); i++)
      run_row(i);
    $display("rows passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- sources.f
csr_pkg.sv
csr_write_stage.sv
csr_storage.sv
csr_read_check.sv
csr_file.sv
csr_file_sva.sv
tb_csr_file.sv

//--- Makefile
# Verilator flow for the supervisor CSR file

TOP := tb_csr_file

.PHONY: lint sim clean

lint:
	verilator --lint-only csr_pkg.sv csr_write_stage.sv csr_storage.sv \
		csr_read_check.sv csr_file.sv --top-module csr_file
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir
